// ==== src.f ====
logic/if_pkg.sv
logic/fetch_if.sv
logic/pc_select.sv
logic/prefetch_unit.sv
logic/instr_predecoder.sv
logic/dummy_insert.sv
logic/if_stage.sv
test/tb_imem.sv
test/tb_if_stage.sv

// ==== Makefile ====
# Verilator flow for the instruction fetch stage

VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= src.f
BUILD_DIR ?= build
LOG       ?= sim.log
JOBS      ?= 4
LINT_OPTS ?= -Wall
SIM_OPTS  ?= -Wno-fatal
PASS_TEXT ?= Done: no errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
COMMON  := --timing --assert --top-module $(TOP) -f $(FILELIST)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(LINT_OPTS) $(COMMON)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary -j $(JOBS) $(SIM_OPTS) $(COMMON) --Mdir $(BUILD_DIR)

# Pass only if the log holds the pass line
sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_if_stage.sv ====
// Fetch stage testbench

`timescale 1ns/10ps

module tb_if_stage import if_pkg::*; ();

  localparam int CLK_PERIOD      = 40;
  localparam int N_PHASES        = 8;
  localparam int WATCHDOG_CYCLES = N_PHASES * 2000;

  logic                clk;
  logic                rst_n;
  logic                pc_set;
  pc_mux_e             pc_mux;
  addr_t               boot_addr;
  addr_t               jump_target;
  addr_t               branch_target;
  addr_t               mepc;
  logic [MTVEC_W-1:0]  mtvec_addr;
  logic [IRQ_ID_W-1:0] irq_id;
  logic                kill_if;
  logic                halt_if;
  logic                dummy_en;
  logic                instr_req;
  logic                instr_gnt;
  addr_t               instr_addr;
  logic                instr_rvalid;
  instr_t              instr_rdata;
  logic                instr_err;
  logic                id_ready;
  logic                id_valid;
  addr_t               id_pc;
  instr_t              id_instr;
  opcode_e             id_opcode;
  logic                id_illegal;
  logic                id_bus_err;
  logic                id_dummy;
  logic                if_busy;
  logic                mtvec_init;
  logic                halt_mode;
  logic                boot_set;
  integer              seed;

  // Expected word for the PC held in ID
  instr_t              probe_word;
  logic                probe_err;
  logic                probe_ill;

  // Scoreboard state
  logic                prev_valid_q;
  logic                prev_ready_q;
  logic                dummy_en_q;
  logic                have_dummy;
  logic                new_entry;
  addr_t               exp_pc_q;
  int                  out_q;
  int                  real_total;
  int                  gap_cnt;
  int                  dummy_seen;
  int                  ill_seen;
  int                  err_seen;
  int                  boot_pulses;

  if_stage uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set),
    .pc_mux_i         (pc_mux),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .irq_id_i         (irq_id),
    .kill_if_i        (kill_if),
    .halt_if_i        (halt_if),
    .dummy_en_i       (dummy_en),
    .instr_req_o      (instr_req),
    .instr_gnt_i      (instr_gnt),
    .instr_addr_o     (instr_addr),
    .instr_rvalid_i   (instr_rvalid),
    .instr_rdata_i    (instr_rdata),
    .instr_err_i      (instr_err),
    .id_ready_i       (id_ready),
    .id_valid_o       (id_valid),
    .id_pc_o          (id_pc),
    .id_instr_o       (id_instr),
    .id_opcode_o      (id_opcode),
    .id_illegal_o     (id_illegal),
    .id_bus_err_o     (id_bus_err),
    .id_dummy_o       (id_dummy),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (mtvec_init)
  );

  tb_imem #(.SEED(32'h56b1_924b)) u_imem (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (instr_req),
    .addr_i       (instr_addr),
    .gnt_o        (instr_gnt),
    .rvalid_o     (instr_rvalid),
    .rdata_o      (instr_rdata),
    .err_o        (instr_err),
    .probe_addr_i (id_pc),
    .probe_word_o (probe_word),
    .probe_err_o  (probe_err),
    .probe_ill_o  (probe_ill)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "Run stopped on a failed check");
  endtask

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    abort_run();
  endtask

  // Redirect target as the address rules define it
  function automatic addr_t redirect_target(input pc_mux_e m);
    addr_t base;
    base = {mtvec_addr, 7'b0000000};
    case (m)
      PC_BOOT:     return boot_addr & ~32'd3;
      PC_JUMP:     return jump_target & ~32'd3;
      PC_BRANCH:   return branch_target & ~32'd3;
      PC_MRET:     return mepc & ~32'd3;
      PC_TRAP_EXC: return base;
      PC_TRAP_IRQ: return base + 32'(irq_id) * 32'd4;
      default:     return boot_addr & ~32'd3;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Clock, random ID side and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // One random draw per cycle keeps the sequence independent of halt_mode
  initial begin
    int r;
    seed     = 32'h56b1_924b;
    id_ready = 1'b0;
    halt_if  = 1'b0;
    forever begin
      @(posedge clk);
      r = $random(seed);
      id_ready <= (r[1:0] != 2'b00);
      halt_if  <= halt_mode && (r[4:3] == 2'b00);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    abort_run();
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  // A word is new when ID was empty or took the previous one
  assign new_entry = id_valid && (!prev_valid_q || prev_ready_q);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_valid_q <= 1'b0;
      prev_ready_q <= 1'b0;
      dummy_en_q   <= 1'b0;
      have_dummy   <= 1'b0;
      exp_pc_q     <= '0;
      out_q        <= 0;
      real_total   <= 0;
      gap_cnt      <= 0;
      dummy_seen   <= 0;
      ill_seen     <= 0;
      err_seen     <= 0;
      boot_pulses  <= 0;
    end else begin
      prev_valid_q <= id_valid;
      prev_ready_q <= id_ready;
      dummy_en_q   <= dummy_en;
      out_q        <= out_q + int'(instr_req && instr_gnt) - int'(instr_rvalid);
      if (mtvec_init) begin
        boot_pulses <= boot_pulses + 1;
      end
      if (new_entry && id_dummy) begin
        dummy_seen <= dummy_seen + 1;
        gap_cnt    <= 0;
        have_dummy <= 1'b1;
      end else if (new_entry) begin
        real_total <= real_total + 1;
        gap_cnt    <= gap_cnt + 1;
        ill_seen   <= ill_seen + int'(id_illegal);
        err_seen   <= err_seen + int'(id_bus_err);
      end
      // Gap is only meaningful between dummies of one enabled stretch
      if (!dummy_en_q) begin
        have_dummy <= 1'b0;
      end
      // Word shown in the redirect cycle still belongs to the old path
      if (pc_set) begin
        exp_pc_q <= redirect_target(pc_mux);
      end else if (new_entry && !id_dummy) begin
        exp_pc_q <= exp_pc_q + 32'd4;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  a_reset_outs: assert property (@(posedge clk)
    !rst_n |-> !id_valid && !instr_req && !if_busy && !mtvec_init)
    else report_mismatch("outputs not low in reset");

  a_boot_init: assert property (@(posedge clk) disable iff (!rst_n)
    mtvec_init == boot_set)
    else report_mismatch("mtvec init does not follow the boot redirect");

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    if_busy == (out_q != 0))
    else report_mismatch($sformatf("if_busy %0b with %0d outstanding", if_busy, out_q));

  a_pc_seq: assert property (@(posedge clk) disable iff (!rst_n)
    new_entry && !id_dummy |-> id_pc == exp_pc_q)
    else report_mismatch($sformatf("id_pc %h, expected %h", id_pc, exp_pc_q));

  a_word: assert property (@(posedge clk) disable iff (!rst_n)
    new_entry && !id_dummy |-> id_instr == probe_word)
    else report_mismatch($sformatf("id_instr %h, expected %h", id_instr, probe_word));

  a_flags: assert property (@(posedge clk) disable iff (!rst_n)
    new_entry && !id_dummy |-> id_bus_err == probe_err && id_illegal == probe_ill)
    else report_mismatch("bus error or illegal flag wrong");

  // Legal words carry the class of their low seven bits
  a_opcode: assert property (@(posedge clk) disable iff (!rst_n)
    new_entry && !id_dummy && !probe_err && !probe_ill
      |-> id_opcode == opcode_e'(probe_word[6:0]))
    else report_mismatch("opcode class wrong for a legal word");

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid && !id_ready |=> id_valid && $stable(id_pc) && $stable(id_instr)
      && $stable(id_opcode) && $stable(id_illegal) && $stable(id_bus_err)
      && $stable(id_dummy))
    else report_mismatch("ID outputs changed under back-pressure");

  a_bus_addr: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req && !instr_gnt |=> instr_req && $stable(instr_addr))
    else report_mismatch("request dropped or address moved before grant");

  a_bus_depth: assert property (@(posedge clk) disable iff (!rst_n)
    out_q <= PF_DEPTH)
    else report_mismatch($sformatf("%0d transactions outstanding", out_q));

  a_dummy_word: assert property (@(posedge clk) disable iff (!rst_n)
    new_entry && id_dummy |-> dummy_en_q && (id_instr[6:0] == OP)
      && (id_instr[11:7] == 5'd0) && (id_opcode == OP))
    else report_mismatch("dummy is not an ADD to x0 or came while disabled");

  a_dummy_gap: assert property (@(posedge clk) disable iff (!rst_n)
    new_entry && id_dummy && have_dummy |-> gap_cnt >= 1 && gap_cnt <= DUMMY_MAX_GAP)
    else report_mismatch($sformatf("%0d real words between dummies", gap_cnt));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Optional kill cycle first, then redirect with kill held
  task automatic redirect(input pc_mux_e m, input logic kill_first);
    if (kill_first) begin
      @(posedge clk);
      kill_if <= 1'b1;
    end
    @(posedge clk);
    pc_set   <= 1'b1;
    pc_mux   <= m;
    kill_if  <= 1'b1;
    boot_set <= (m == PC_BOOT);
    @(posedge clk);
    pc_set   <= 1'b0;
    kill_if  <= 1'b0;
    boot_set <= 1'b0;
  endtask

  task automatic wait_real(input int n);
    int goal;
    goal = real_total + n;
    while (real_total < goal) begin
      @(posedge clk);
    end
  endtask

  initial begin
    rst_n         = 1'b0;
    pc_set        = 1'b0;
    pc_mux        = PC_BOOT;
    boot_addr     = 32'h0000_1002;
    jump_target   = 32'h0000_10f9;
    branch_target = 32'h0000_1040;
    mepc          = 32'h0000_1303;
    mtvec_addr    = 25'h24;
    irq_id        = 5'd3;
    kill_if       = 1'b0;
    dummy_en      = 1'b0;
    halt_mode     = 1'b0;
    boot_set      = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Boot runs into the illegal window
    redirect(PC_BOOT, 1'b0);
    wait_real(80);
    // Jump just below the illegal window
    redirect(PC_JUMP, 1'b0);
    wait_real(20);
    // Trap and vectored interrupt land in the error window
    redirect(PC_TRAP_EXC, 1'b0);
    wait_real(20);
    redirect(PC_TRAP_IRQ, 1'b0);
    wait_real(12);
    // Halt bursts, then a kill ahead of the redirect
    halt_mode <= 1'b1;
    redirect(PC_MRET, 1'b0);
    wait_real(30);
    redirect(PC_BRANCH, 1'b1);
    wait_real(20);
    halt_mode <= 1'b0;
    // Dummies on, then off again
    dummy_en <= 1'b1;
    wait_real(120);
    dummy_en <= 1'b0;
    wait_real(40);
    if ((dummy_seen > 0) && (ill_seen > 0) && (err_seen > 0) && (boot_pulses == 1)) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Stimulus missed a case: dummies %0d, illegal %0d, bus errors %0d, boots %0d",
               dummy_seen, ill_seen, err_seen, boot_pulses);
      abort_run();
    end
  end

endmodule

// ==== test/tb_imem.sv ====
// Instruction memory model

`timescale 1ns/10ps

module tb_imem import if_pkg::*; #(
  parameter logic [31:0] SEED = 32'h56b1_924b
) (
  input  logic   clk,
  input  logic   rst_n,
  // OBI slave side
  input  logic   req_i,
  input  addr_t  addr_i,
  output logic   gnt_o,
  output logic   rvalid_o,
  output instr_t rdata_o,
  output logic   err_o,
  // Lookup of the stored word for the checker
  input  addr_t  probe_addr_i,
  output instr_t probe_word_o,
  output logic   probe_err_o,
  output logic   probe_ill_o
);

  // Illegal opcode window and bus error window
  localparam addr_t ILL_LO = 32'h0000_1100;
  localparam addr_t ILL_HI = 32'h0000_1140;
  localparam addr_t ERR_LO = 32'h0000_1200;
  localparam addr_t ERR_HI = 32'h0000_1240;

  integer      seed;
  logic        gnt_roll;
  int unsigned now;
  int unsigned last_due;
  int unsigned due;
  addr_t       pend_addr [$];
  int unsigned pend_due  [$];

  function automatic logic in_ill(input addr_t a);
    return (a >= ILL_LO) && (a < ILL_HI);
  endfunction

  function automatic logic in_err(input addr_t a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  // ADDI with every address bit folded into the fields
  function automatic instr_t word_at(input addr_t a);
    logic [11:0] imm;
    imm = a[13:2] ^ a[25:14] ^ {6'b000000, a[31:26]};
    if (in_err(a)) begin
      return '0;
    end
    if (in_ill(a)) begin
      return {imm, a[6:2], 3'b000, a[11:7], 7'h7f};
    end
    return {imm, a[6:2], 3'b000, a[11:7], 7'h13};
  endfunction

  initial begin
    seed = SEED;
  end

  assign gnt_o        = req_i && gnt_roll;
  assign probe_word_o = word_at(probe_addr_i);
  assign probe_err_o  = in_err(probe_addr_i);
  assign probe_ill_o  = in_ill(probe_addr_i);

  ////////////////////////////////////////////////////////////////////////////
  // Grant and in-order response queue
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_roll <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      now      = 0;
      last_due = 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      // Grant about three cycles in four
      gnt_roll <= ($random(seed) & 3) != 0;
      rvalid_o <= 1'b0;
      if ((pend_due.size() > 0) && (pend_due[0] <= now)) begin
        rvalid_o <= 1'b1;
        rdata_o  <= word_at(pend_addr[0]);
        err_o    <= in_err(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // Latency 1 to 4 cycles, never overtaking an older request
      if (req_i && gnt_o) begin
        due = now + 1 + ($random(seed) & 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(addr_i);
        pend_due.push_back(due);
      end
      now = now + 1;
    end
  end

endmodule

// ==== logic/if_stage.sv ====
// Instruction fetch stage

`timescale 1ns/10ps

module if_stage import if_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // Control and targets
  input  logic                pc_set_i,
  input  pc_mux_e             pc_mux_i,
  input  addr_t               boot_addr_i,
  input  addr_t               jump_target_i,
  input  addr_t               branch_target_i,
  input  addr_t               mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                kill_if_i,
  input  logic                halt_if_i,
  input  logic                dummy_en_i,
  // OBI instruction bus
  output logic                instr_req_o,
  input  logic                instr_gnt_i,
  output addr_t               instr_addr_o,
  input  logic                instr_rvalid_i,
  input  instr_t              instr_rdata_i,
  input  logic                instr_err_i,
  // IF/ID register
  input  logic                id_ready_i,
  output logic                id_valid_o,
  output addr_t               id_pc_o,
  output instr_t              id_instr_o,
  output opcode_e             id_opcode_o,
  output logic                id_illegal_o,
  output logic                id_bus_err_o,
  output logic                id_dummy_o,
  // Status
  output logic                if_busy_o,
  output logic                csr_mtvec_init_o
);

  addr_t   branch_addr;
  opcode_e pre_opcode;
  logic    pre_illegal;
  logic    dummy_ins;
  instr_t  dummy_word;
  logic    if_valid;
  logic    issued;

  fetch_if fetch_bus ();

  pc_select u_pc_select (
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .irq_id_i        (irq_id_i),
    .branch_addr_o   (branch_addr)
  );

  prefetch_unit u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .req_o         (instr_req_o),
    .gnt_i         (instr_gnt_i),
    .addr_o        (instr_addr_o),
    .rvalid_i      (instr_rvalid_i),
    .rdata_i       (instr_rdata_i),
    .err_i         (instr_err_i),
    .fetch         (fetch_bus),
    .busy_o        (if_busy_o)
  );

  instr_predecoder u_predec (
    .instr_i   (fetch_bus.rdata),
    .err_i     (fetch_bus.err),
    .opcode_o  (pre_opcode),
    .illegal_o (pre_illegal)
  );

  dummy_insert u_dummy (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (dummy_en_i),
    .issued_i      (issued),
    .insert_o      (dummy_ins),
    .dummy_instr_o (dummy_word)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stage handshake
  ////////////////////////////////////////////////////////////////////////////

  // Dummy also waits for a buffered word, whose PC it borrows
  assign if_valid = fetch_bus.valid && !kill_if_i && !halt_if_i;

  // Kill drains the buffer, dummy keeps the real word in place
  assign fetch_bus.ready = kill_if_i || (id_ready_i && !dummy_ins && !halt_if_i);

  assign issued = if_valid && id_ready_i;

  // mtvec init request on boot
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o   <= 1'b0;
      id_instr_o   <= INSTR_NOP;
      id_illegal_o <= 1'b0;
      id_bus_err_o <= 1'b0;
      id_dummy_o   <= 1'b0;
    end else if (issued) begin
      id_valid_o   <= 1'b1;
      id_instr_o   <= dummy_ins ? dummy_word : fetch_bus.rdata;
      id_illegal_o <= dummy_ins ? 1'b0 : pre_illegal;
      id_bus_err_o <= dummy_ins ? 1'b0 : fetch_bus.err;
      id_dummy_o   <= dummy_ins;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;
    end
  end

  // Address and class of the issued word
  always_ff @(posedge clk) begin
    if (issued) begin
      id_pc_o     <= fetch_bus.addr;
      id_opcode_o <= dummy_ins ? OP : pre_opcode;
    end
  end

endmodule

// ==== logic/dummy_insert.sv ====
// Dummy instruction insertion

`timescale 1ns/10ps

module dummy_insert import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   enable_i,
  input  logic   issued_i,
  output logic   insert_o,
  output instr_t dummy_instr_o
);

  logic [31:0]      lfsr_q;
  logic [GAP_W-1:0] gap_q;
  logic [GAP_W-1:0] gap_load;

  // Gap of 1..DUMMY_MAX_GAP real issues
  assign gap_load = GAP_W'(lfsr_q[GAP_W-2:0]) + GAP_W'(1);

  assign insert_o = enable_i && (gap_q == '0);

  // Everything moves only on an issue edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_SEED;
      gap_q  <= GAP_W'(LFSR_SEED[GAP_W-2:0]) + GAP_W'(1);
    end else if (issued_i) begin
      lfsr_q <= {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);
      if (insert_o) begin
        // Dummy went out, start a new gap
        gap_q <= gap_load;
      end else if (gap_q != '0) begin
        gap_q <= gap_q - GAP_W'(1);
      end
    end
  end

  // add x0, rs1, rs2 with random sources
  assign dummy_instr_o = {7'b0000000, lfsr_q[14:10], lfsr_q[19:15], 3'b000, 5'b00000, OP};

  a_no_dummy_off: assert property (@(posedge clk) disable iff (!rst_n)
    !enable_i |-> !insert_o);

endmodule

// ==== logic/instr_predecoder.sv ====
// Instruction predecoder

`timescale 1ns/10ps

module instr_predecoder import if_pkg::*; (
  input  instr_t  instr_i,
  input  logic    err_i,
  output opcode_e opcode_o,
  output logic    illegal_o
);

  logic known;

  // Major opcode lookup
  always_comb begin
    // Unknown encodings report the NOP class
    opcode_o = OP_IMM;
    known    = 1'b0;
    case (instr_i[6:0])
      LOAD,
      STORE,
      OP_IMM,
      OP,
      LUI,
      AUIPC,
      JAL,
      JALR,
      BRANCH,
      SYSTEM,
      MISC_MEM: begin
        opcode_o = opcode_e'(instr_i[6:0]);
        known    = 1'b1;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  // Compressed quadrants are not supported
  // Bus error wins, the word content is meaningless then
  assign illegal_o = !err_i && ((instr_i[1:0] != 2'b11) || !known);

endmodule

// ==== logic/prefetch_unit.sv ====
// Instruction prefetcher

`timescale 1ns/10ps

module prefetch_unit import if_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   pc_set_i,
  input  addr_t  branch_addr_i,
  // OBI instruction bus
  output logic   req_o,
  input  logic   gnt_i,
  output addr_t  addr_o,
  input  logic   rvalid_i,
  input  instr_t rdata_i,
  input  logic   err_i,
  // Buffered words toward the stage
  fetch_if.src   fetch,
  output logic   busy_o
);

  pf_state_e           state_q;
  pf_state_e           state_d;
  addr_t               addr_q;
  addr_t               tgt_q;
  addr_t               rsp_addr_q;
  logic [PF_CNT_W-1:0] out_cnt_q;
  logic [PF_CNT_W-1:0] out_cnt_d;
  logic [PF_CNT_W-1:0] drop_cnt_q;
  logic [PF_CNT_W-1:0] drop_cnt_d;
  logic [PF_CNT_W-1:0] fifo_cnt_q;
  logic [PF_PTR_W-1:0] wr_ptr_q;
  logic [PF_PTR_W-1:0] rd_ptr_q;
  addr_t               fifo_addr [PF_DEPTH];
  instr_t              fifo_data [PF_DEPTH];
  logic                fifo_err  [PF_DEPTH];
  logic                gnt_ok;
  logic                drop;
  logic                push;
  logic                pop;

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  // Total can only shrink without a grant, so req never drops early
  assign req_o  = (state_q != IDLE) && ((out_cnt_q + fifo_cnt_q) < PF_CNT_W'(PF_DEPTH));
  assign addr_o = addr_q;
  assign gnt_ok = req_o && gnt_i;

  // Old-path responses, a response in the redirect cycle included
  assign drop = rvalid_i && (pc_set_i || (drop_cnt_q != '0));
  assign push = rvalid_i && !drop;
  assign pop  = fetch.valid && fetch.ready;

  assign out_cnt_d = out_cnt_q + PF_CNT_W'(gnt_ok) - PF_CNT_W'(rvalid_i);

  // Everything still in flight after a redirect belongs to the old path
  always_comb begin
    drop_cnt_d = drop_cnt_q;
    if (pc_set_i) begin
      drop_cnt_d = out_cnt_d;
    end else begin
      if (rvalid_i && (drop_cnt_q != '0)) begin
        drop_cnt_d = drop_cnt_d - PF_CNT_W'(1);
      end
      // Grant of the stale request held over a redirect
      if (gnt_ok && (state_q == FLUSH)) begin
        drop_cnt_d = drop_cnt_d + PF_CNT_W'(1);
      end
    end
  end

  // FLUSH keeps an ungranted old request on the bus until its grant
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (pc_set_i) begin
          state_d = FETCH;
        end
      end
      FETCH: begin
        if (pc_set_i && req_o && !gnt_i) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        if (gnt_ok) begin
          state_d = FETCH;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      out_cnt_q  <= '0;
      drop_cnt_q <= '0;
      fifo_cnt_q <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      addr_q     <= '0;
      rsp_addr_q <= '0;
    end else begin
      state_q    <= state_d;
      out_cnt_q  <= out_cnt_d;
      drop_cnt_q <= drop_cnt_d;
      // Redirect empties the buffer, first kept response is the target
      if (pc_set_i) begin
        fifo_cnt_q <= '0;
        rd_ptr_q   <= wr_ptr_q;
        rsp_addr_q <= branch_addr_i;
      end else begin
        fifo_cnt_q <= fifo_cnt_q + PF_CNT_W'(push) - PF_CNT_W'(pop);
        if (push) begin
          wr_ptr_q   <= wr_ptr_q + PF_PTR_W'(1);
          rsp_addr_q <= rsp_addr_q + 32'd4;
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + PF_PTR_W'(1);
        end
      end
      // Next request address
      if (pc_set_i && (state_d != FLUSH)) begin
        addr_q <= branch_addr_i;
      end else if (gnt_ok) begin
        addr_q <= (state_q == FLUSH) ? tgt_q : addr_q + 32'd4;
      end
    end
  end

  // Redirect target and buffer storage
  always_ff @(posedge clk) begin
    if (pc_set_i) begin
      tgt_q <= branch_addr_i;
    end
    if (push) begin
      fifo_addr[wr_ptr_q] <= rsp_addr_q;
      fifo_data[wr_ptr_q] <= rdata_i;
      fifo_err[wr_ptr_q]  <= err_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage side
  ////////////////////////////////////////////////////////////////////////////

  // Never offer an old-path word in the redirect cycle
  assign fetch.valid = (fifo_cnt_q != '0) && !pc_set_i;
  assign fetch.addr  = fifo_addr[rd_ptr_q];
  assign fetch.rdata = fifo_data[rd_ptr_q];
  assign fetch.err   = fifo_err[rd_ptr_q];

  assign busy_o = (out_cnt_q != '0);

  // Waiting request holds address until granted, redirects included
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_o && !gnt_i |=> req_o && $stable(addr_o));

  // In-flight plus buffered words fit the buffer
  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
    (out_cnt_q + fifo_cnt_q) <= PF_DEPTH);

endmodule

// ==== logic/pc_select.sv ====
// Fetch address select

`timescale 1ns/10ps

module pc_select import if_pkg::*; (
  input  pc_mux_e             pc_mux_i,
  input  addr_t               boot_addr_i,
  input  addr_t               jump_target_i,
  input  addr_t               branch_target_i,
  input  addr_t               mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  output addr_t               branch_addr_o
);

  // Fetch is word-aligned only, so bits [1:0] are always dropped
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: begin
        branch_addr_o = {boot_addr_i[31:2], 2'b00};
      end
      PC_JUMP: begin
        branch_addr_o = {jump_target_i[31:2], 2'b00};
      end
      PC_BRANCH: begin
        branch_addr_o = {branch_target_i[31:2], 2'b00};
      end
      // Return to the interrupted instruction
      PC_MRET: begin
        branch_addr_o = {mepc_i[31:2], 2'b00};
      end
      // All exceptions share the mtvec base
      PC_TRAP_EXC: begin
        branch_addr_o = {mtvec_addr_i, 7'h00};
      end
      // Vectored, base + 4 * id
      PC_TRAP_IRQ: begin
        branch_addr_o = {mtvec_addr_i, irq_id_i, 2'b00};
      end
      default: begin
        branch_addr_o = {boot_addr_i[31:2], 2'b00};
      end
    endcase
  end

endmodule

// ==== logic/fetch_if.sv ====
// Buffered fetch channel

`timescale 1ns/10ps

interface fetch_if;

  // Handshake, word moves when both are high
  logic        valid;
  logic        ready;

  // Word payload and its byte address
  logic [31:0] addr;
  logic [31:0] rdata;

  // Bus error reported with the response
  logic        err;

  // Prefetcher side
  modport src (
    output valid,
    output addr,
    output rdata,
    output err,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid,
    input  addr,
    input  rdata,
    input  err,
    output ready
  );

endinterface

// ==== logic/if_pkg.sv ====
// Fetch stage types and constants

package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////////////////////////////////////////

  // Byte address and raw instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // Source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_MRET,
    PC_TRAP_EXC,
    PC_TRAP_IRQ
  } pc_mux_e;

  // RV32I major opcodes, encoded as instr[6:0]
  typedef enum logic [6:0] {
    LOAD     = 7'b0000011,
    STORE    = 7'b0100011,
    OP_IMM   = 7'b0010011,
    OP       = 7'b0110011,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    JAL      = 7'b1101111,
    JALR     = 7'b1100111,
    BRANCH   = 7'b1100011,
    SYSTEM   = 7'b1110011,
    MISC_MEM = 7'b0001111
  } opcode_e;

  // Prefetcher FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    FLUSH
  } pf_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int MTVEC_W  = 25;
  localparam int IRQ_ID_W = 5;

  // Outstanding plus buffered words never exceed this
  localparam int PF_DEPTH = 2;
  localparam int PF_CNT_W = $clog2(PF_DEPTH + 1);
  localparam int PF_PTR_W = $clog2(PF_DEPTH);

  // Dummy pacing, gap counter holds 0..DUMMY_MAX_GAP
  localparam int DUMMY_MAX_GAP = 16;
  localparam int GAP_W         = $clog2(DUMMY_MAX_GAP) + 1;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_SEED = 32'h3c6e_f372;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // ADDI x0,x0,0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage
